// File: hw/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    localparam int ROB_DEPTH_DEF = 8;
    localparam int REG_COUNT = 32;

    // major opcodes handled by decode
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MUL,
        OP_BEQ,
        OP_BNE,
        OP_BLT
    } alu_op_e;

    // branch offset is scattered over funct7 and rd of the register view
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
    } inst_word_u;

endpackage

`default_nettype wire

// File: hw/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder #(
    parameter int ROB_DEPTH = ooo_pkg::ROB_DEPTH_DEF,
    localparam int TAG_W = $clog2(ROB_DEPTH),
    localparam int REG_W = $clog2(ooo_pkg::REG_COUNT)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             inst_valid,
    input  logic [31:0]      inst,
    input  logic [31:0]      inst_pc,
    input  logic             pred_taken,
    input  logic [31:0]      rs1_data,
    input  logic             rs1_busy,
    input  logic [31:0]      rs2_data,
    input  logic             rs2_busy,
    input  logic             full,
    input  logic [TAG_W-1:0] alloc_tag,
    input  logic             flush,
    input  logic             mul_busy_next,
    output logic             stall,
    output logic [REG_W-1:0] rs1,
    output logic [REG_W-1:0] rs2,
    output logic             claim_en,
    output logic [REG_W-1:0] claim_rd,
    output logic [TAG_W-1:0] claim_tag,
    output logic             alloc_en,
    output logic [REG_W-1:0] alloc_rd,
    output logic             alloc_is_branch,
    output logic             alloc_pred_taken,
    output logic             issue_en,
    output ooo_pkg::alu_op_e issue_op,
    output logic [TAG_W-1:0] issue_tag,
    output logic [31:0]      issue_a,
    output logic [31:0]      issue_b,
    output logic [31:0]      issue_pc,
    output logic [31:0]      issue_imm
);
    import ooo_pkg::*;

    inst_word_u       iw;
    alu_op_e          op;
    logic [31:0]      imm;
    logic [REG_W-1:0] rd;
    logic             is_op;
    logic             is_imm;
    logic             is_br;
    logic             writes_rd;
    logic             accept;
    logic             issue_vld;

    assign iw = inst;
    assign is_op = (iw.r_fmt.opcode == OPC_OP);
    assign is_imm = (iw.i_fmt.opcode == OPC_OP_IMM);
    assign is_br = (iw.r_fmt.opcode == OPC_BRANCH);
    assign rd = iw.r_fmt.rd;
    assign rs1 = iw.r_fmt.rs1;
    assign rs2 = iw.r_fmt.rs2;
    assign writes_rd = (is_op | is_imm) && (rd != '0);

    always_comb begin
        op = OP_ADD;
        imm = {{20{iw.i_fmt.imm[11]}}, iw.i_fmt.imm};
        if (is_op) begin
            case (iw.r_fmt.funct3)
                3'd4: op = OP_XOR;
                3'd6: op = OP_OR;
                3'd7: op = OP_AND;
                default: begin
                    if (iw.r_fmt.funct7 == 7'h01) begin
                        op = OP_MUL;
                    end else if (iw.r_fmt.funct7 == 7'h20) begin
                        op = OP_SUB;
                    end
                end
            endcase
        end else if (is_br) begin
            imm = {{19{iw.r_fmt.funct7[6]}}, iw.r_fmt.funct7[6], iw.r_fmt.rd[0],
                   iw.r_fmt.funct7[5:0], iw.r_fmt.rd[4:1], 1'b0};
            case (iw.r_fmt.funct3)
                3'd1: op = OP_BNE;
                3'd4: op = OP_BLT;
                default: op = OP_BEQ;
            endcase
        end
    end

    // no forwarding, so wait for the writer to commit
    assign stall = full
                 | (rs1_busy & (is_op | is_imm | is_br))
                 | (rs2_busy & (is_op | is_br))
                 | (mul_busy_next & (op != OP_MUL));
    assign accept = inst_valid & ~stall;

    assign claim_en = accept & writes_rd;
    assign claim_rd = rd;
    assign claim_tag = alloc_tag;
    assign alloc_en = accept;
    assign alloc_rd = writes_rd ? rd : '0;
    assign alloc_is_branch = is_br;
    assign alloc_pred_taken = pred_taken;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_vld <= 1'b0;
        end else begin
            issue_vld <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue_op <= op;
            issue_tag <= alloc_tag;
            issue_a <= rs1_data;
            issue_b <= is_imm ? imm : rs2_data;
            issue_pc <= inst_pc;
            issue_imm <= imm;
        end
    end

    // wrong-path instruction sitting in the issue register
    assign issue_en = issue_vld & ~flush;

endmodule

`default_nettype wire

// File: hw/reg_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module reg_scoreboard #(
    parameter int ROB_DEPTH = ooo_pkg::ROB_DEPTH_DEF,
    localparam int TAG_W = $clog2(ROB_DEPTH),
    localparam int REG_W = $clog2(ooo_pkg::REG_COUNT)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [REG_W-1:0] rs1,
    input  logic [REG_W-1:0] rs2,
    input  logic             claim_en,
    input  logic [REG_W-1:0] claim_rd,
    input  logic [TAG_W-1:0] claim_tag,
    input  logic             commit_en,
    input  logic [REG_W-1:0] commit_rd,
    input  logic [31:0]      commit_data,
    input  logic [TAG_W-1:0] commit_tag,
    input  logic             flush,
    output logic [31:0]      rs1_data,
    output logic             rs1_busy,
    output logic [31:0]      rs2_data,
    output logic             rs2_busy
);
    import ooo_pkg::*;

    logic [31:0]          regs [REG_COUNT];
    logic [REG_COUNT-1:0] busy;
    logic [TAG_W-1:0]     owner [REG_COUNT];

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];
    assign rs1_busy = busy[rs1];
    assign rs2_busy = busy[rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            busy <= '0;
        end else begin
            if (commit_en && commit_rd != '0) begin
                regs[commit_rd] <= commit_data;
                // a younger claim keeps the register busy
                if (owner[commit_rd] == commit_tag) begin
                    busy[commit_rd] <= 1'b0;
                end
            end
            if (flush) begin
                busy <= '0;
            end
            // new claim wins over commit and flush
            if (claim_en) begin
                busy[claim_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (claim_en) begin
            owner[claim_rd] <= claim_tag;
        end
    end

endmodule

`default_nettype wire

// File: hw/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit #(
    parameter int ROB_DEPTH = ooo_pkg::ROB_DEPTH_DEF,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             issue_en,
    input  ooo_pkg::alu_op_e issue_op,
    input  logic [TAG_W-1:0] issue_tag,
    input  logic [31:0]      issue_a,
    input  logic [31:0]      issue_b,
    input  logic [31:0]      issue_pc,
    input  logic [31:0]      issue_imm,
    input  logic             flush,
    output logic             done_en,
    output logic [TAG_W-1:0] done_tag,
    output logic [31:0]      done_data,
    output logic             done_taken,
    output logic [31:0]      done_next_pc,
    output logic             mul_busy_next
);
    import ooo_pkg::*;

    logic             alu_fire;
    logic             mul_fire;
    logic [31:0]      alu_data;
    logic             alu_taken;
    logic [31:0]      alu_next_pc;
    logic             m1_valid;
    logic [TAG_W-1:0] m1_tag;
    logic [31:0]      m1_a;
    logic [31:0]      m1_b;
    logic [31:0]      mul_lo;
    logic             m2_valid;
    logic [TAG_W-1:0] m2_tag;
    logic [31:0]      m2_prod;
    logic             skid_valid;
    logic             skid_valid_n;
    logic             skid_load;
    logic [TAG_W-1:0] skid_tag;
    logic [31:0]      skid_data;
    logic             skid_taken;
    logic [31:0]      skid_next_pc;

    assign mul_fire = issue_en && (issue_op == OP_MUL);
    assign alu_fire = issue_en && (issue_op != OP_MUL);

    always_comb begin
        alu_data = '0;
        alu_taken = 1'b0;
        case (issue_op)
            OP_ADD: alu_data = issue_a + issue_b;
            OP_SUB: alu_data = issue_a - issue_b;
            OP_AND: alu_data = issue_a & issue_b;
            OP_OR: alu_data = issue_a | issue_b;
            OP_XOR: alu_data = issue_a ^ issue_b;
            OP_BEQ: alu_taken = (issue_a == issue_b);
            OP_BNE: alu_taken = (issue_a != issue_b);
            OP_BLT: alu_taken = ($signed(issue_a) < $signed(issue_b));
            default: alu_data = '0;
        endcase
    end

    assign alu_next_pc = alu_taken ? issue_pc + issue_imm : issue_pc + 32'd4;
    assign mul_lo = m1_a * m1_b;

    // priority on the done port: mul, then skid, then fresh alu
    assign skid_load = alu_fire & (m2_valid | skid_valid);
    assign skid_valid_n = m2_valid ? (skid_valid | alu_fire) : (skid_valid & alu_fire);
    // skid still full while the next mul lands
    assign mul_busy_next = m1_valid & skid_valid_n;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            m1_valid <= 1'b0;
            m2_valid <= 1'b0;
            skid_valid <= 1'b0;
            done_en <= 1'b0;
        end else begin
            m1_valid <= mul_fire;
            m2_valid <= m1_valid;
            skid_valid <= skid_valid_n;
            done_en <= m2_valid | skid_valid | alu_fire;
        end
    end

    always_ff @(posedge clk) begin
        m1_tag <= issue_tag;
        m1_a <= issue_a;
        m1_b <= issue_b;
        m2_tag <= m1_tag;
        m2_prod <= mul_lo;
        if (skid_load) begin
            skid_tag <= issue_tag;
            skid_data <= alu_data;
            skid_taken <= alu_taken;
            skid_next_pc <= alu_next_pc;
        end
        if (m2_valid) begin
            done_tag <= m2_tag;
            done_data <= m2_prod;
            done_taken <= 1'b0;
            done_next_pc <= '0;
        end else if (skid_valid) begin
            done_tag <= skid_tag;
            done_data <= skid_data;
            done_taken <= skid_taken;
            done_next_pc <= skid_next_pc;
        end else begin
            done_tag <= issue_tag;
            done_data <= alu_data;
            done_taken <= alu_taken;
            done_next_pc <= alu_next_pc;
        end
    end

endmodule

`default_nettype wire

// File: hw/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
    parameter int ROB_DEPTH = ooo_pkg::ROB_DEPTH_DEF,
    localparam int TAG_W = $clog2(ROB_DEPTH),
    localparam int REG_W = $clog2(ooo_pkg::REG_COUNT)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             alloc_en,
    input  logic [REG_W-1:0] alloc_rd,
    input  logic             alloc_is_branch,
    input  logic             alloc_pred_taken,
    input  logic             done_en,
    input  logic [TAG_W-1:0] done_tag,
    input  logic [31:0]      done_data,
    input  logic             done_taken,
    input  logic [31:0]      done_next_pc,
    output logic [TAG_W-1:0] alloc_tag,
    output logic             full,
    output logic             commit_en,
    output logic [REG_W-1:0] commit_rd,
    output logic [31:0]      commit_data,
    output logic [TAG_W-1:0] commit_tag,
    output logic             redirect,
    output logic [31:0]      redirect_pc
);

    logic [ROB_DEPTH-1:0] ent_valid;
    logic [ROB_DEPTH-1:0] ent_done;
    logic [REG_W-1:0]     ent_rd [ROB_DEPTH];
    logic [31:0]          ent_data [ROB_DEPTH];
    logic                 ent_branch [ROB_DEPTH];
    logic                 ent_pred [ROB_DEPTH];
    logic                 ent_taken [ROB_DEPTH];
    logic [31:0]          ent_next_pc [ROB_DEPTH];
    logic [TAG_W-1:0]     head;
    logic [TAG_W-1:0]     tail;
    logic [TAG_W:0]       count;
    logic                 head_commit;
    logic                 mispredict;

    function automatic logic [TAG_W-1:0] ptr_inc(input logic [TAG_W-1:0] p);
        return (p == TAG_W'(ROB_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign alloc_tag = tail;
    assign full = (count == (TAG_W + 1)'(ROB_DEPTH));
    // nothing retires in the flush cycle
    assign head_commit = ent_valid[head] & ent_done[head] & ~redirect;
    assign mispredict = ent_branch[head] & (ent_taken[head] != ent_pred[head]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ent_valid <= '0;
            ent_done <= '0;
            head <= '0;
            tail <= '0;
            count <= '0;
            commit_en <= 1'b0;
            redirect <= 1'b0;
        end else begin
            commit_en <= head_commit;
            redirect <= head_commit & mispredict;
            if (redirect) begin
                // empty out, the slot at tail stays usable for a new alloc
                ent_valid <= '0;
                head <= tail;
                count <= {{TAG_W{1'b0}}, alloc_en};
            end else begin
                if (head_commit) begin
                    ent_valid[head] <= 1'b0;
                    head <= ptr_inc(head);
                end
                if (done_en) begin
                    ent_done[done_tag] <= 1'b1;
                end
                count <= count + (TAG_W + 1)'(alloc_en) - (TAG_W + 1)'(head_commit);
            end
            if (alloc_en) begin
                ent_valid[tail] <= 1'b1;
                ent_done[tail] <= 1'b0;
                tail <= ptr_inc(tail);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            ent_rd[tail] <= alloc_rd;
            ent_branch[tail] <= alloc_is_branch;
            ent_pred[tail] <= alloc_pred_taken;
        end
        if (done_en) begin
            ent_data[done_tag] <= done_data;
            ent_taken[done_tag] <= done_taken;
            ent_next_pc[done_tag] <= done_next_pc;
        end
        if (head_commit) begin
            commit_rd <= ent_rd[head];
            commit_data <= ent_data[head];
            commit_tag <= head;
            redirect_pc <= ent_next_pc[head];
        end
    end

endmodule

`default_nettype wire

// File: hw/ooo_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_top #(
    parameter int ROB_DEPTH = ooo_pkg::ROB_DEPTH_DEF,
    localparam int TAG_W = $clog2(ROB_DEPTH),
    localparam int REG_W = $clog2(ooo_pkg::REG_COUNT)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             inst_valid,
    input  logic [31:0]      inst,
    input  logic [31:0]      inst_pc,
    input  logic             pred_taken,
    output logic             stall,
    output logic             commit_en,
    output logic [REG_W-1:0] commit_rd,
    output logic [31:0]      commit_data,
    output logic             redirect,
    output logic [31:0]      redirect_pc
);
    import ooo_pkg::*;

    // decode and register file
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic [31:0]      rs1_data;
    logic             rs1_busy;
    logic [31:0]      rs2_data;
    logic             rs2_busy;
    logic             claim_en;
    logic [REG_W-1:0] claim_rd;
    logic [TAG_W-1:0] claim_tag;

    // allocation
    logic             alloc_en;
    logic [REG_W-1:0] alloc_rd;
    logic             alloc_is_branch;
    logic             alloc_pred_taken;
    logic [TAG_W-1:0] alloc_tag;
    logic             full;

    // issue and completion
    logic             issue_en;
    alu_op_e          issue_op;
    logic [TAG_W-1:0] issue_tag;
    logic [31:0]      issue_a;
    logic [31:0]      issue_b;
    logic [31:0]      issue_pc;
    logic [31:0]      issue_imm;
    logic             done_en;
    logic [TAG_W-1:0] done_tag;
    logic [31:0]      done_data;
    logic             done_taken;
    logic [31:0]      done_next_pc;
    logic             mul_busy_next;
    logic [TAG_W-1:0] commit_tag;

    inst_decoder #(.ROB_DEPTH(ROB_DEPTH)) u_decoder (
        .flush(redirect),
        .*
    );

    reg_scoreboard #(.ROB_DEPTH(ROB_DEPTH)) u_scoreboard (
        .flush(redirect),
        .*
    );

    exec_unit #(.ROB_DEPTH(ROB_DEPTH)) u_exec (
        .flush(redirect),
        .*
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .*
    );

endmodule

`default_nettype wire

// File: test/rob_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rob_checker (
    input logic       clk,
    input logic       rst_n,
    input logic       alloc_en,
    input logic       full,
    input logic       commit_en,
    input logic [4:0] commit_rd,
    input logic       redirect
);

    // reset is synchronous, outputs settle one edge later
    reset_quiet: assert property (@(posedge clk) !rst_n |=> (!commit_en && !redirect))
        else $error("commit or redirect active while in reset");

    no_alloc_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(full && alloc_en))
        else $error("entry allocated while the reorder buffer is full");

    // redirect is raised by the committing branch, which writes no register
    redirect_with_commit: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> (commit_en && commit_rd == '0))
        else $error("redirect raised without a branch commit");

endmodule

`default_nettype wire

// File: test/ooo_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb;

    localparam int ROB_DEPTH = 8;
    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_CYCLES = 20;
    localparam int MEM_WORDS = 256;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] inst_pc;
    logic        pred_taken;
    logic        stall;
    logic        commit_en;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;
    logic        redirect;
    logic [31:0] redirect_pc;

    logic [31:0] tdata [0:MEM_WORDS-1];
    logic [31:0] prog_pc [$];
    logic [31:0] prog_inst [$];
    logic        prog_pred [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_redirect [$];

    logic [31:0] pc;
    logic        accepted;
    logic        stall_seen = 1'b0;
    int          in_flight = 0;
    int          commits_seen = 0;
    int          redirects_seen = 0;
    int          cycle_count = 0;
    int          cycle_limit;

    ooo_core_top #(.ROB_DEPTH(ROB_DEPTH)) DUT (
        .clk(clk),
        .rst_n(rst_n),
        .inst_valid(inst_valid),
        .inst(inst),
        .inst_pc(inst_pc),
        .pred_taken(pred_taken),
        .stall(stall),
        .commit_en(commit_en),
        .commit_rd(commit_rd),
        .commit_data(commit_data),
        .redirect(redirect),
        .redirect_pc(redirect_pc)
    );

    bind reorder_buffer rob_checker u_rob_checker (
        .clk(clk),
        .rst_n(rst_n),
        .alloc_en(alloc_en),
        .full(full),
        .commit_en(commit_en),
        .commit_rd(commit_rd),
        .redirect(redirect)
    );

    always #10 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            report_failure($sformatf("Timeout: core stopped committing after %0d of %0d commits",
                                     commits_seen, exp_rd.size()));
        end
    end

    task automatic load_testdata();
        int pos;
        int n;
        $readmemh("test/ooo_core_testdata.txt", tdata);
        assert (!$isunknown(tdata[0])) else report_failure("testdata file could not be read");
        n = tdata[0];
        pos = 1;
        for (int i = 0; i < n; i++) begin
            prog_pc.push_back(tdata[pos]);
            prog_inst.push_back(tdata[pos + 1]);
            prog_pred.push_back(tdata[pos + 2][0]);
            pos += 3;
        end
        n = tdata[pos];
        pos++;
        for (int i = 0; i < n; i++) begin
            exp_rd.push_back(tdata[pos][4:0]);
            exp_data.push_back(tdata[pos + 1]);
            pos += 2;
        end
        n = tdata[pos];
        pos++;
        for (int i = 0; i < n; i++) begin
            exp_redirect.push_back(tdata[pos]);
            pos++;
        end
    endtask

    function automatic int find_record(input logic [31:0] addr);
        for (int i = 0; i < prog_pc.size(); i++) begin
            if (prog_pc[i] == addr) begin
                return i;
            end
        end
        return -1;
    endfunction

    // a zero word or an unknown pc ends the program
    task automatic present_inst(input logic [31:0] addr);
        int idx;
        idx = find_record(addr);
        inst_pc = addr;
        if (idx < 0 || prog_inst[idx] == 32'h0) begin
            inst_valid = 1'b0;
            inst = '0;
            pred_taken = 1'b0;
        end else begin
            inst_valid = 1'b1;
            inst = prog_inst[idx];
            pred_taken = prog_pred[idx];
        end
    endtask

    task automatic check_commit();
        assert (commits_seen < exp_rd.size())
            else report_failure("commit seen after the expected sequence was complete");
        assert (commit_rd == exp_rd[commits_seen])
            else report_failure($sformatf("Fail commit_rd expected %h got %h",
                                          exp_rd[commits_seen], commit_rd));
        // rd zero writes nothing, data is don't care
        if (exp_rd[commits_seen] != 5'd0) begin
            assert (commit_data == exp_data[commits_seen])
                else report_failure($sformatf("Fail commit_data expected %h got %h",
                                              exp_data[commits_seen], commit_data));
        end
        if (redirect) begin
            assert (redirects_seen < exp_redirect.size())
                else report_failure("redirect raised for a correctly predicted branch");
            assert (redirect_pc == exp_redirect[redirects_seen])
                else report_failure($sformatf("Fail redirect_pc expected %h got %h",
                                              exp_redirect[redirects_seen], redirect_pc));
            redirects_seen++;
        end
        commits_seen++;
    endtask

    initial begin
        rst_n = 1'b0;
        inst_valid = 1'b0;
        inst = '0;
        inst_pc = '0;
        pred_taken = 1'b0;
        load_testdata();
        cycle_limit = 40 * prog_pc.size() + RESET_CYCLES + DRAIN_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        pc = '0;
        present_inst(pc);
        while (commits_seen < exp_rd.size()) begin
            @(negedge clk);
            accepted = inst_valid && !stall;
            // an empty core takes the next word at once
            if (inst_valid && in_flight == 0) begin
                assert (!stall)
                    else report_failure("stall raised with no instruction in flight");
            end
            if (inst_valid && stall) begin
                stall_seen = 1'b1;
            end
            if (commit_en) begin
                check_commit();
                in_flight--;
            end
            // only the word taken in the redirect cycle survives the flush
            if (redirect) begin
                in_flight = 0;
            end
            if (accepted) begin
                in_flight++;
            end
            @(posedge clk);
            #2;
            // fetch follows the redirect, otherwise steps past an accepted word
            if (redirect) begin
                pc = redirect_pc;
            end else if (accepted) begin
                pc = pc + 32'd4;
            end
            present_inst(pc);
        end
        inst_valid = 1'b0;
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            assert (!commit_en) else report_failure("extra commit after the last expected one");
        end
        assert (redirects_seen == exp_redirect.size())
            else report_failure($sformatf("only %0d of %0d expected redirects were raised",
                                          redirects_seen, exp_redirect.size()));
        assert (in_flight == 0)
            else report_failure($sformatf("%0d accepted instructions never committed",
                                          in_flight));
        assert (stall_seen)
            else report_failure("stall never rose while an instruction was waiting");
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/ooo_core_testdata.txt
// program: record count, then pc, instruction word, predicted taken
// expected: commit count, then rd and data pairs; redirect count and redirect pcs
1D
00000000 00500093 0
00000004 FFD00113 0
00000008 002081B3 0
0000000C 40208233 0
00000010 0020F2B3 0
00000014 0020E333 0
00000018 0020C3B3 0
0000001C 02108433 0
00000020 00700493 0
00000024 00900513 0
00000028 029405B3 0
0000002C 00A58633 0
00000030 F3860613 0
00000034 00949863 0
00000038 00108663 0
0000003C 00100693 0
00000040 00200713 0
00000044 0020C463 1
00000048 02908833 0
0000004C 029108B3 0
00000050 02A20933 0
00000054 022389B3 0
00000058 02840A33 0
0000005C 02A58AB3 0
00000060 02430B33 0
00000064 02C60BB3 0
00000068 02A18C33 0
0000006C 02728CB3 0
00000070 00000000 0
1A
01 00000005 02 FFFFFFFD
03 00000002 04 00000008
05 00000005 06 FFFFFFFD
07 FFFFFFF8 08 00000019
09 00000007 0A 00000009
0B 000000AF 0C 000000B8
0C FFFFFFF0 00 00000000
00 00000000 00 00000000
10 00000023 11 FFFFFFEB
12 00000048 13 00000018
14 00000271 15 00000627
16 FFFFFFE8 17 00000100
18 00000012 19 FFFFFFD8
02 00000044 00000048

// File: all.f
hw/ooo_pkg.sv
hw/inst_decoder.sv
hw/reg_scoreboard.sv
hw/exec_unit.sv
hw/reorder_buffer.sv
hw/ooo_core_top.sv
test/rob_checker.sv
test/ooo_core_tb.sv
